/* fetch_defines.svh */
// Fetch stage widths, memory sizing, bubble word, reset PC and APB register offsets
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Instruction and address width
`define FETCH_WORD 16

// Instruction memory, word addressed by PC[8:1]
`define FETCH_IMEM_DEPTH 256
`define FETCH_IMEM_AW 8

// Bubble inserted on a load-use hazard
`define FETCH_NOP_WORD 16'h0800

`define FETCH_RESET_PC 16'h0000

// APB register offsets
`define FETCH_REG_CTRL 5'h00
`define FETCH_REG_STATUS 5'h04
`define FETCH_REG_PC 5'h08
`define FETCH_REG_IADDR 5'h0C
`define FETCH_REG_IDATA 5'h10

`endif

/* fetchPkg.sv */
// Opcode, destination-select and APB state enums plus the decoded control bundle
package fetchPkg;

    // Major opcode in instr[15:11]
    typedef enum logic [4:0] {
        OP_HALT = 5'b00000,
        OP_NOP  = 5'b00001,
        OP_J    = 5'b00100,
        OP_JR   = 5'b00101,
        OP_JAL  = 5'b00110,
        OP_ADDI = 5'b01000,
        OP_BEQZ = 5'b01100,
        OP_ST   = 5'b10000,
        OP_LD   = 5'b10001,
        OP_ALU  = 5'b11011
    } opcodeT;

    // Where the write-back register number comes from
    typedef enum logic [1:0] {
        DEST_RS   = 2'b00, // instr[10:8]
        DEST_RD_R = 2'b01, // instr[4:2]
        DEST_R7   = 2'b10, // link register
        DEST_RD_I = 2'b11  // instr[7:5]
    } destSelT;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } apbStateT;

    // Control fields handed to later stages
    typedef struct packed {
        logic       regWrite;
        destSelT    destSel;
        logic       regJmp;
        logic       memEnable;
        logic       memWr;
        logic       val2Reg;
        logic       aluSel;
        logic [2:0] immSel;
        logic       linkReg;
        logic       halt;
    } ctrlBundleT;

endpackage

/* imemLoadIf.sv */
// Instruction memory load and read-back interface with register-block and memory modports
`timescale 1ns/1ps
`include "fetch_defines.svh"

interface imemLoadIf;
    logic                      wrEn;   // One cycle, stores on next edge
    logic [`FETCH_IMEM_AW-1:0] addr;   // Word index
    logic [`FETCH_WORD-1:0]    wrData;
    logic [`FETCH_WORD-1:0]    rdData; // Combinational from addr

    modport csr (
        output wrEn,
        output addr,
        output wrData,
        input  rdData
    );

    modport mem (
        input  wrEn,
        input  addr,
        input  wrData,
        output rdData
    );
endinterface

/* pcUnit.sv */
// Program counter with halt flag, restart, stall and next-address priority select
`timescale 1ns/1ps
`include "fetch_defines.svh"

module pcUnit (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   runEn,
    input  logic                   stall,
    input  logic                   restart,
    input  logic                   haltReq,
    input  logic                   pcSel,
    input  logic                   regJmp,
    input  logic [`FETCH_WORD-1:0] brnchAddr,
    input  logic [`FETCH_WORD-1:0] imm,
    input  logic [`FETCH_WORD-1:0] rs,
    output logic [`FETCH_WORD-1:0] pc
);
    logic                   halted;
    logic                   advance;
    logic [`FETCH_WORD-1:0] nextPc;

    // Only a running, unstalled, unhalted stage moves
    assign advance = runEn & ~stall & ~halted;

    always_comb begin
        if (pcSel) begin
            nextPc = brnchAddr;    // Taken branch from later stage
        end else if (regJmp) begin
            nextPc = rs + imm;     // JR target
        end else begin
            nextPc = pc + `FETCH_WORD'd2;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc     <= `FETCH_RESET_PC;
            halted <= 1'b0;
        end else if (restart) begin
            pc     <= `FETCH_RESET_PC;
            halted <= 1'b0;
        end else if (advance) begin
            if (haltReq) begin
                halted <= 1'b1;    // PC stays on the HALT word
            end else begin
                pc <= nextPc;
            end
        end
    end

endmodule

/* instrMem.sv */
// Word-addressed instruction memory with async fetch port and APB load/read-back port
`timescale 1ns/1ps
`include "fetch_defines.svh"

module instrMem (
    input  logic                   clk,
    imemLoadIf.mem                 load,
    input  logic [`FETCH_WORD-1:0] pc,
    output logic [`FETCH_WORD-1:0] fetchWord
);
    logic [`FETCH_WORD-1:0]    mem [`FETCH_IMEM_DEPTH];
    logic [`FETCH_IMEM_AW-1:0] fetchIdx;

    // Byte PC, bit 0 ignored
    assign fetchIdx = pc[`FETCH_IMEM_AW:1];

    assign fetchWord = mem[fetchIdx];

    // Read-back for the register block
    assign load.rdData = mem[load.addr];

    always_ff @(posedge clk) begin
        if (load.wrEn) begin
            mem[load.addr] <= load.wrData;
        end
    end

endmodule

/* hazardDetect.sv */
// Load-use hazard detector raising a one-cycle NOP and PC stall
`timescale 1ns/1ps
`include "fetch_defines.svh"

module hazardDetect (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [`FETCH_WORD-1:0] instr,
    input  logic                   issueLoad,
    input  logic [2:0]             loadDest,
    output logic                   nop,
    output logic                   pcStall
);
    import fetchPkg::*;

    logic       ldPending;   // LD issued, held through its bubble
    logic [2:0] ldDest;
    logic       stalledLast; // Bubble already inserted for this word
    logic       hasSources;
    logic       srcMatch;
    opcodeT     fetchOp;

    assign fetchOp = opcodeT'(instr[15:11]);

    // NOP and HALT read no registers
    assign hasSources = (fetchOp != OP_NOP) && (fetchOp != OP_HALT);

    assign srcMatch = (instr[10:8] == ldDest) || (instr[7:5] == ldDest);

    assign nop     = ldPending & ~stalledLast & hasSources & srcMatch;
    assign pcStall = nop;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ldPending   <= 1'b0;
            ldDest      <= 3'd0;
            stalledLast <= 1'b0;
        end else begin
            ldPending   <= issueLoad | pcStall;
            stalledLast <= pcStall;
            if (issueLoad) begin
                ldDest <= loadDest;
            end
        end
    end

endmodule

/* controlDecode.sv */
// Opcode to control bundle decoder with undefined-opcode error flag
`timescale 1ns/1ps

module controlDecode (
    input  fetchPkg::opcodeT     opcode,
    output fetchPkg::ctrlBundleT ctrl,
    output logic                 ctrlErr
);
    import fetchPkg::*;

    // Immediate format codes
    localparam logic [2:0] IMM_NONE = 3'b000;
    localparam logic [2:0] IMM_5    = 3'b001; // instr[4:0], sign extended
    localparam logic [2:0] IMM_8    = 3'b010; // instr[7:0]
    localparam logic [2:0] IMM_11   = 3'b100; // instr[10:0] jump displacement

    always_comb begin
        ctrl    = '0;
        ctrl.destSel = DEST_RS;
        ctrl.immSel  = IMM_NONE;
        ctrlErr = 1'b0;

        case (opcode)
            OP_ALU: begin
                ctrl.regWrite = 1'b1;
                ctrl.destSel  = DEST_RD_R;
            end
            OP_ADDI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSel   = 1'b1; // Second operand from immediate
                ctrl.destSel  = DEST_RD_I;
                ctrl.immSel   = IMM_5;
            end
            OP_LD: begin
                ctrl.memEnable = 1'b1;
                ctrl.val2Reg   = 1'b1; // Write back memory data
                ctrl.regWrite  = 1'b1;
                ctrl.destSel   = DEST_RD_I;
                ctrl.immSel    = IMM_5;
            end
            OP_ST: begin
                ctrl.memEnable = 1'b1;
                ctrl.memWr     = 1'b1;
                ctrl.immSel    = IMM_5;
            end
            OP_JAL: begin
                ctrl.regWrite = 1'b1;
                ctrl.linkReg  = 1'b1; // PC+2 into R7
                ctrl.destSel  = DEST_R7;
                ctrl.immSel   = IMM_11;
            end
            OP_JR: begin
                ctrl.regJmp = 1'b1;
                ctrl.immSel = IMM_8;
            end
            OP_J: begin
                ctrl.immSel = IMM_11; // Target resolved downstream
            end
            OP_BEQZ: begin
                ctrl.immSel = IMM_8;
            end
            OP_HALT: begin
                ctrl.halt = 1'b1;
            end
            OP_NOP: begin
                ctrl.destSel = DEST_RS;
            end
            default: begin
                // Unknown opcode, everything stays low
                ctrlErr = 1'b1;
            end
        endcase
    end

endmodule

/* fetchCsr.sv */
// APB register block for run control, status, PC readout and instruction memory loading
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetchCsr (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [4:0]             paddr,
    input  logic [`FETCH_WORD-1:0] pwdata,
    output logic [`FETCH_WORD-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr,
    imemLoadIf.csr                 load,
    input  logic [`FETCH_WORD-1:0] pc,
    input  logic                   haltSeen,
    input  logic                   ctrlErr,
    output logic                   runEn,
    output logic                   restart
);
    import fetchPkg::*;

    apbStateT                  apbState;
    logic                      access;
    logic                      mapped;
    logic                      roReg;
    logic                      wrAccess;
    logic                      halted;
    logic                      errSticky;
    logic [`FETCH_IMEM_AW-1:0] iaddr;

    always_comb begin
        if (!psel) begin
            apbState = IDLE;
        end else if (!penable) begin
            apbState = SETUP;
        end else begin
            apbState = ACCESS;
        end
    end

    assign access = (apbState == ACCESS);
    assign mapped = (paddr == `FETCH_REG_CTRL) || (paddr == `FETCH_REG_STATUS) ||
                    (paddr == `FETCH_REG_PC) || (paddr == `FETCH_REG_IADDR) ||
                    (paddr == `FETCH_REG_IDATA);
    assign roReg  = (paddr == `FETCH_REG_STATUS) || (paddr == `FETCH_REG_PC);

    assign wrAccess = access & pwrite & mapped & ~roReg;
    assign pready   = 1'b1; // Zero wait states
    assign pslverr  = access & (~mapped | (pwrite & roReg));

    // IDATA write goes straight into memory at IADDR
    assign load.wrEn   = wrAccess & (paddr == `FETCH_REG_IDATA);
    assign load.addr   = iaddr;
    assign load.wrData = pwdata;

    always_comb begin
        case (paddr)
            `FETCH_REG_CTRL:   prdata = {{(`FETCH_WORD-1){1'b0}}, runEn};
            `FETCH_REG_STATUS: prdata = {{(`FETCH_WORD-3){1'b0}}, runEn & ~halted,
                                         errSticky, halted};
            `FETCH_REG_PC:     prdata = pc;
            `FETCH_REG_IADDR:  prdata = {{(`FETCH_WORD-`FETCH_IMEM_AW){1'b0}}, iaddr};
            `FETCH_REG_IDATA:  prdata = load.rdData;
            default:           prdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            runEn   <= 1'b0;
            restart <= 1'b0;
            iaddr   <= '0;
        end else begin
            restart <= 1'b0; // Self-clearing
            if (wrAccess && paddr == `FETCH_REG_CTRL) begin
                runEn   <= pwdata[0];
                restart <= pwdata[1];
            end
            if (wrAccess && paddr == `FETCH_REG_IADDR) begin
                iaddr <= pwdata[`FETCH_IMEM_AW-1:0];
            end else if (load.wrEn) begin
                iaddr <= iaddr + 1'b1;
            end
        end
    end

    // Sticky status, restart wins
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            halted    <= 1'b0;
            errSticky <= 1'b0;
        end else if (restart) begin
            halted    <= 1'b0;
            errSticky <= 1'b0;
        end else begin
            if (haltSeen) halted <= 1'b1;
            if (ctrlErr) errSticky <= 1'b1;
        end
    end

endmodule

/* fetchStage.sv */
// Fetch stage joining PC, instruction memory, hazard unit and decoder with NOP and dest muxes
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetchStage (
    input  logic                   clk,
    input  logic                   rstN,
    imemLoadIf.mem                 load,
    input  logic                   runEn,
    input  logic                   restart,
    input  logic                   pcSel,
    input  logic [`FETCH_WORD-1:0] brnchAddr,
    input  logic [`FETCH_WORD-1:0] imm,
    input  logic [`FETCH_WORD-1:0] rs,
    output logic [`FETCH_WORD-1:0] instr,
    output logic [`FETCH_WORD-1:0] pc,
    output fetchPkg::ctrlBundleT   ctrl,
    output logic [2:0]             writeRegAddr,
    output logic                   ctrlErr,
    output logic                   haltSeen
);
    import fetchPkg::*;

    logic [`FETCH_WORD-1:0] fetchWord;
    logic                   nop;
    logic                   pcStall;
    logic                   issueLoad;
    opcodeT                 opcode;

    pcUnit uPc (
        .clk, .rstN, .runEn, .restart, .pcSel, .brnchAddr, .imm, .rs, .pc,
        .stall   (pcStall),
        .haltReq (ctrl.halt),
        .regJmp  (ctrl.regJmp)
    );

    instrMem uMem (.clk, .load, .pc, .fetchWord);

    hazardDetect uHaz (
        .clk, .rstN, .nop, .pcStall, .issueLoad,
        .instr    (fetchWord),   // Raw word, before the bubble mux
        .loadDest (writeRegAddr)
    );

    // Bubble while idle or on a hazard
    assign instr  = (nop || !runEn) ? `FETCH_NOP_WORD : fetchWord;
    assign opcode = opcodeT'(instr[15:11]);

    controlDecode uDec (.opcode, .ctrl, .ctrlErr);

    assign issueLoad = (opcode == OP_LD);
    assign haltSeen  = ctrl.halt;

    always_comb begin
        case (ctrl.destSel)
            DEST_RS:   writeRegAddr = instr[10:8];
            DEST_RD_R: writeRegAddr = instr[4:2];
            DEST_R7:   writeRegAddr = 3'd7;
            DEST_RD_I: writeRegAddr = instr[7:5];
            default:   writeRegAddr = instr[4:2];
        endcase
    end

endmodule

/* fetchTop.sv */
// Fetch top level with APB and pipeline ports, register block and fetch stage
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetchTop (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [4:0]             paddr,
    input  logic [`FETCH_WORD-1:0] pwdata,
    output logic [`FETCH_WORD-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  logic                   pcSel,
    input  logic [`FETCH_WORD-1:0] brnchAddr,
    input  logic [`FETCH_WORD-1:0] imm,
    input  logic [`FETCH_WORD-1:0] rs,
    output logic [`FETCH_WORD-1:0] instr,
    output logic [`FETCH_WORD-1:0] pc,
    output logic [2:0]             writeRegAddr,
    output logic                   regWrite,
    output logic                   regJmp,
    output logic                   memEnable,
    output logic                   memWr,
    output logic                   val2Reg,
    output logic                   aluSel,
    output logic [2:0]             immSel,
    output logic                   linkReg,
    output logic                   halt,
    output logic                   ctrlErr
);
    import fetchPkg::*;

    ctrlBundleT ctrl;
    logic       runEn;
    logic       restart;
    logic       haltSeen;

    imemLoadIf loadBus ();

    fetchCsr uCsr (
        .clk, .rstN, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
        .pready, .pslverr, .pc, .haltSeen, .ctrlErr, .runEn, .restart,
        .load (loadBus.csr)
    );

    fetchStage uStage (
        .clk, .rstN, .runEn, .restart, .pcSel, .brnchAddr, .imm, .rs,
        .instr, .pc, .ctrl, .writeRegAddr, .ctrlErr, .haltSeen,
        .load (loadBus.mem)
    );

    // Flatten bundle for later stages
    assign regWrite  = ctrl.regWrite;
    assign regJmp    = ctrl.regJmp;
    assign memEnable = ctrl.memEnable;
    assign memWr     = ctrl.memWr;
    assign val2Reg   = ctrl.val2Reg;
    assign aluSel    = ctrl.aluSel;
    assign immSel    = ctrl.immSel;
    assign linkReg   = ctrl.linkReg;
    assign halt      = ctrl.halt;

endmodule

/* clkGen.sv */
// Testbench clock and reset generator
`timescale 1ns/1ps

module clkGen (
    output logic clk,
    output logic rstN
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    initial begin
        rstN = 1'b0;
        repeat (2) @(posedge clk);
        #1 rstN = 1'b1; // Released with the other inputs
    end

endmodule

/* tb_fetchTop.sv */
// Fetch stage testbench with APB tasks, reference model, program stimulus and checks
`timescale 1ns/1ps
`include "fetch_defines.svh"

module tb_fetchTop;
    import fetchPkg::*;

    // Tests take about 300 cycles
    localparam int MAX_CYCLES = 2000;

    logic        clk, rstN, psel, penable, pwrite, pready, pslverr, pcSel, ctrlErr;
    logic [4:0]  paddr;
    logic [15:0] pwdata, prdata, brnchAddr, imm, rs, instr, pc;
    logic [2:0]  writeRegAddr, immSel;
    logic        regWrite, regJmp, memEnable, memWr, val2Reg, aluSel, linkReg, halt;
    logic [7:0]  actBits;

    // Reference model state
    logic [15:0] prog [`FETCH_IMEM_DEPTH];
    logic [15:0] progBuf [32];
    logic [15:0] mPc, rawWord, expInstr;
    logic [7:0]  mIaddr, expBits;
    logic [2:0]  mLdDest;
    logic        mRun, mRestart, mHalted, mLdPend, mStalled, bubble;
    logic        ctrlWrite, iaddrWrite, idataWrite;
    int          bubbleCount;
    int          cycleCount = 0;
    integer      seed;
    string       testName;
    apbStateT    apbPhase;

    clkGen uClk (.clk, .rstN);

    fetchTop DUT (
        .clk, .rstN, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
        .pslverr, .pcSel, .brnchAddr, .imm, .rs, .instr, .pc, .writeRegAddr,
        .regWrite, .regJmp, .memEnable, .memWr, .val2Reg, .aluSel, .immSel,
        .linkReg, .halt, .ctrlErr
    );

    assign actBits = {regWrite, regJmp, memEnable, memWr, val2Reg, aluSel, linkReg, halt};

    // Bus phase drives the APB select and enable
    assign psel    = (apbPhase != IDLE);
    assign penable = (apbPhase == ACCESS);

    // {regWrite, regJmp, memEnable, memWr, val2Reg, aluSel, linkReg, halt}
    function automatic logic [7:0] expectCtrl(input logic [15:0] word);
        case (word[15:11])
            OP_ALU:  return 8'b1000_0000;
            OP_ADDI: return 8'b1000_0100;
            OP_LD:   return 8'b1010_1000;
            OP_ST:   return 8'b0011_0000;
            OP_JAL:  return 8'b1000_0010;
            OP_JR:   return 8'b0100_0000;
            OP_HALT: return 8'b0000_0001;
            default: return 8'b0000_0000;
        endcase
    endfunction

    function automatic logic isDefined(input logic [4:0] op);
        case (op)
            OP_HALT, OP_NOP, OP_J, OP_JR, OP_JAL, OP_ADDI,
            OP_BEQZ, OP_ST, OP_LD, OP_ALU: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [2:0] expectDest(input logic [15:0] word);
        case (word[15:11])
            OP_ALU:        return word[4:2];
            OP_ADDI, OP_LD: return word[7:5];
            OP_JAL:        return 3'd7;
            default:       return word[10:8];
        endcase
    endfunction

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic reportMismatch(input string what, input logic [15:0] expVal,
                                  input logic [15:0] actVal);
        $display("ERR %s: %s expected %h actual %h", testName, what, expVal, actVal);
        abortRun("First mismatch, run stopped");
    endtask

    // Setup phase, access phase, then back to idle
    task automatic busTransfer(input logic wr, input logic [4:0] addr, input logic [15:0] data,
                               output logic [15:0] rdVal, output logic err);
        apbPhase = SETUP;
        pwrite   = wr;
        paddr    = addr;
        pwdata   = data;
        @(posedge clk);
        #1;
        apbPhase = ACCESS;
        @(negedge clk);
        assert (pready === 1'b1) else reportMismatch("pready", 16'd1, {15'd0, pready});
        rdVal = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        apbPhase = IDLE;
        pwrite   = 1'b0;
    endtask

    task automatic writeReg(input logic [4:0] addr, input logic [15:0] data);
        logic [15:0] rdVal;
        logic        err;
        busTransfer(1'b1, addr, data, rdVal, err);
        assert (err === 1'b0) else reportMismatch("pslverr on write", 16'd0, {15'd0, err});
    endtask

    task automatic checkReg(input logic [4:0] addr, input logic [15:0] expVal, input string what);
        logic [15:0] rdVal;
        logic        err;
        busTransfer(1'b0, addr, 16'd0, rdVal, err);
        assert (err === 1'b0) else reportMismatch("pslverr on read", 16'd0, {15'd0, err});
        assert (rdVal === expVal) else reportMismatch(what, expVal, rdVal);
    endtask

    task automatic expectSlvErr(input logic wr, input logic [4:0] addr, input string what);
        logic [15:0] rdVal;
        logic        err;
        busTransfer(wr, addr, 16'h5a5a, rdVal, err);
        assert (err === 1'b1) else reportMismatch(what, 16'd1, {15'd0, err});
    endtask

    task automatic loadProgram(input int n);
        writeReg(`FETCH_REG_IADDR, 16'd0);
        for (int i = 0; i < n; i++) begin
            writeReg(`FETCH_REG_IDATA, progBuf[i]);
        end
    endtask

    // Stop, restart to PC 0 and clear status
    task automatic prepareTest(input string name);
        testName = name;
        writeReg(`FETCH_REG_CTRL, 16'h0002);
    endtask

    task automatic waitForHalt();
        @(negedge clk);
        while (halt !== 1'b1) @(negedge clk);
        repeat (3) @(posedge clk);
        #1;
    endtask

    assign ctrlWrite  = psel && penable && pwrite && (paddr == `FETCH_REG_CTRL);
    assign iaddrWrite = psel && penable && pwrite && (paddr == `FETCH_REG_IADDR);
    assign idataWrite = psel && penable && pwrite && (paddr == `FETCH_REG_IDATA);

    always_comb begin
        rawWord = prog[mPc[8:1]];
        // NOP and HALT read no registers
        bubble  = mLdPend && !mStalled && (rawWord[15:11] != OP_NOP) &&
                  (rawWord[15:11] != OP_HALT) &&
                  ((rawWord[10:8] == mLdDest) || (rawWord[7:5] == mLdDest));
        expInstr = (bubble || !mRun) ? `FETCH_NOP_WORD : rawWord;
        expBits  = expectCtrl(expInstr);
    end

    always @(posedge clk) begin
        if (idataWrite) prog[mIaddr] <= pwdata;
    end

    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mPc         <= `FETCH_RESET_PC;
            mRun        <= 1'b0;
            mRestart    <= 1'b0;
            mHalted     <= 1'b0;
            mLdPend     <= 1'b0;
            mLdDest     <= 3'd0;
            mStalled    <= 1'b0;
            mIaddr      <= 8'd0;
            bubbleCount <= 0;
        end else begin
            mLdPend  <= (expInstr[15:11] == OP_LD);
            mStalled <= bubble;
            mRestart <= ctrlWrite & pwdata[1]; // One-cycle pulse
            if (expInstr[15:11] == OP_LD) mLdDest <= expInstr[7:5];
            if (bubble) bubbleCount <= bubbleCount + 1;
            if (ctrlWrite) mRun <= pwdata[0];
            if (iaddrWrite) begin
                mIaddr <= pwdata[7:0];
            end else if (idataWrite) begin
                mIaddr <= mIaddr + 8'd1;
            end
            if (mRestart) begin
                mPc     <= `FETCH_RESET_PC;
                mHalted <= 1'b0;
            end else if (mRun && !bubble && !mHalted) begin
                if (expBits[0]) begin
                    mHalted <= 1'b1;
                end else if (pcSel) begin
                    mPc <= brnchAddr;
                end else if (expBits[6]) begin
                    mPc <= rs + imm; // JR target
                end else begin
                    mPc <= mPc + 16'd2;
                end
            end
        end
    end

    // Outputs are settled mid-cycle
    always @(negedge clk) begin
        if (rstN) begin
            assert (pc === mPc) else reportMismatch("pc", mPc, pc);
            assert (instr === expInstr) else reportMismatch("instr", expInstr, instr);
            assert (actBits === expBits) else reportMismatch("ctrl bits", {8'd0, expBits},
                                                             {8'd0, actBits});
            assert (ctrlErr === !isDefined(expInstr[15:11]))
                else reportMismatch("ctrlErr", {15'd0, !isDefined(expInstr[15:11])},
                                    {15'd0, ctrlErr});
            if (!isDefined(expInstr[15:11])) begin
                assert (immSel === 3'd0) else reportMismatch("immSel", 16'd0, {13'd0, immSel});
            end
            if (expBits[7]) begin
                assert (writeRegAddr === expectDest(expInstr))
                    else reportMismatch("writeRegAddr", {13'd0, expectDest(expInstr)},
                                        {13'd0, writeRegAddr});
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= MAX_CYCLES) begin
            abortRun("Timeout: the tests did not finish within the cycle limit");
        end
    end

    initial begin
        logic [31:0] pick;
        seed      = 66339;
        testName  = "reset";
        apbPhase  = IDLE;
        pwrite    = 1'b0;
        paddr     = 5'd0;
        pwdata    = 16'd0;
        pcSel     = 1'b0;
        brnchAddr = 16'd0;
        imm       = 16'd0;
        rs        = 16'd0;
        wait (rstN === 1'b1);
        @(posedge clk);
        #1;

        testName = "apbLoad";
        writeReg(`FETCH_REG_IADDR, 16'h0020);
        for (int i = 0; i < 4; i++) begin
            progBuf[i] = $random(seed);
            writeReg(`FETCH_REG_IDATA, progBuf[i]);
        end
        checkReg(`FETCH_REG_IADDR, 16'h0024, "iaddr after increment");
        for (int i = 0; i < 4; i++) begin
            writeReg(`FETCH_REG_IADDR, 16'h0020 + i);
            checkReg(`FETCH_REG_IDATA, progBuf[i], "idata read-back");
        end
        expectSlvErr(1'b0, 5'h14, "pslverr unmapped read");
        expectSlvErr(1'b1, `FETCH_REG_PC, "pslverr pc write");
        expectSlvErr(1'b1, `FETCH_REG_STATUS, "pslverr status write");

        prepareTest("seqFetch");
        for (int i = 0; i < 12; i++) begin
            pick = $random(seed);
            case (pick[1:0])
                2'd0:    progBuf[i] = {OP_ALU, pick[26:16]};
                2'd1:    progBuf[i] = {OP_ADDI, pick[26:16]};
                2'd2:    progBuf[i] = {OP_ST, pick[26:16]};
                default: progBuf[i] = {OP_JAL, pick[26:16]};
            endcase
        end
        progBuf[12] = 16'h0000; // HALT
        loadProgram(13);
        writeReg(`FETCH_REG_CTRL, 16'h0001);
        waitForHalt();
        checkReg(`FETCH_REG_STATUS, 16'h0001, "status halted");
        checkReg(`FETCH_REG_PC, 16'd24, "pc at halt");

        prepareTest("loadUse");
        progBuf[0] = {OP_LD, 3'd1, 3'd3, 5'd4};
        progBuf[1] = {OP_ALU, 3'd3, 3'd1, 3'd2, 2'b00}; // Reads r3
        progBuf[2] = {OP_LD, 3'd2, 3'd5, 5'd0};
        progBuf[3] = {OP_ADDI, 3'd1, 3'd2, 5'd7};       // Independent
        progBuf[4] = {OP_LD, 3'd0, 3'd6, 5'd2};
        progBuf[5] = {OP_ST, 3'd1, 3'd6, 5'd3};         // r6 in bits 7:5
        progBuf[6] = 16'h0000;
        loadProgram(7);
        writeReg(`FETCH_REG_CTRL, 16'h0001);
        waitForHalt();
        checkReg(`FETCH_REG_PC, 16'd12, "pc at halt");
        assert (bubbleCount == 2) else reportMismatch("bubble count", 16'd2, 16'(bubbleCount));

        prepareTest("redirect");
        for (int i = 0; i < 16; i++) begin
            progBuf[i] = {OP_ALU, 11'($random(seed))};
        end
        progBuf[8]  = {OP_JR, 3'd2, 8'd8};
        progBuf[16] = 16'h0000;
        rs  = 16'h0018;
        imm = 16'h0008;
        loadProgram(17);
        writeReg(`FETCH_REG_CTRL, 16'h0001);
        @(posedge clk);
        #1;
        pcSel     = 1'b1;
        brnchAddr = 16'h0010;
        @(posedge clk);
        #1;
        pcSel = 1'b0;
        waitForHalt();
        checkReg(`FETCH_REG_PC, 16'h0020, "pc after jr");

        prepareTest("haltRestart");
        progBuf[0] = {OP_ALU, 11'($random(seed))};
        progBuf[1] = {OP_ADDI, 11'($random(seed))};
        progBuf[2] = 16'h0000;
        loadProgram(3);
        writeReg(`FETCH_REG_CTRL, 16'h0001);
        waitForHalt();
        checkReg(`FETCH_REG_STATUS, 16'h0001, "status halted");
        checkReg(`FETCH_REG_PC, 16'd4, "pc frozen");
        writeReg(`FETCH_REG_CTRL, 16'h0002);
        checkReg(`FETCH_REG_STATUS, 16'h0000, "status after restart");
        checkReg(`FETCH_REG_PC, 16'd0, "pc after restart");

        prepareTest("badOpcode");
        progBuf[0] = {OP_ALU, 11'($random(seed))};
        progBuf[1] = {5'b11111, 11'($random(seed))};
        progBuf[2] = {OP_ADDI, 11'($random(seed))};
        progBuf[3] = {5'b00010, 11'($random(seed))};
        progBuf[4] = 16'h0000;
        loadProgram(5);
        writeReg(`FETCH_REG_CTRL, 16'h0001);
        waitForHalt();
        checkReg(`FETCH_REG_STATUS, 16'h0003, "status error and halt");
        checkReg(`FETCH_REG_PC, 16'd8, "pc at halt");

        $display("=== PASS ===");
        $finish;
    end

endmodule

/* fetchTop.f */
+incdir+.
fetchPkg.sv
imemLoadIf.sv
pcUnit.sv
instrMem.sv
hazardDetect.sv
controlDecode.sv
fetchCsr.sv
fetchStage.sv
fetchTop.sv
clkGen.sv
tb_fetchTop.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fetchTop
FILELIST  ?= fetchTop.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR) -o V$(TOP)
	-$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
